// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

   // Byte address seen by the core.
   typedef logic [31:0] addr_t;

   // One instruction word.
   typedef logic [31:0] inst_t;

   // Fetch control.
   // Idle until the first redirect supplies a boot address.
   typedef enum logic {
      fs_idle,
      fs_fetch
   } fetch_state_t;

endpackage

`default_nettype wire

// File: logic/icache_pkg.sv
`default_nettype none

package icache_pkg;

   // Line geometry of the instruction cache.
   localparam int WORDS_PER_LINE = 4;
   localparam int LINE_BYTES     = 4 * WORDS_PER_LINE;

   // Word k sits in bits 32k+31 down to 32k.
   typedef logic [32*WORDS_PER_LINE-1:0] line_t;

   // Word index inside a line, taken from address bits 3..2.
   typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

endpackage

`default_nettype wire

// File: logic/fetch_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// Control path between the fetch address generator and the line buffer.
interface fill_ctrl_if;

   core_pkg::addr_t fill_pc;
   logic            push;
   logic            flush;
   logic            full;

   modport generator (
      output fill_pc,
      output push,
      output flush,
      input  full
   );

   modport buffer (
      input  fill_pc,
      input  push,
      input  flush,
      output full
   );

endinterface

// Oldest queued line as offered to the dispatch side.
interface line_head_if;

   icache_pkg::line_t head_line;
   core_pkg::addr_t   head_pc;
   logic              empty;
   logic              pop;

   modport buffer (
      output head_line,
      output head_pc,
      output empty,
      input  pop
   );

   modport reader (
      input  head_line,
      input  head_pc,
      input  empty,
      output pop
   );

endinterface

`default_nettype wire

// File: logic/fetch_pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_pc_gen (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  jump_branch_valid,
   input  wire core_pkg::addr_t jump_branch_address,
   input  wire                  icache_dout_valid,
   output logic                 icache_rd_en,
   output logic                 icache_abort,
   fill_ctrl_if.generator       fill
);

   // Clears the offset bits inside a line.
   localparam core_pkg::addr_t LINE_MASK =
      ~core_pkg::addr_t'(icache_pkg::LINE_BYTES - 1);

   core_pkg::fetch_state_t state;
   core_pkg::fetch_state_t state_nxt;
   core_pkg::addr_t        line_pc;

   // Leave idle on the first redirect, then keep fetching.
   always_comb begin
      state_nxt = state;
      if (jump_branch_valid) begin
         state_nxt = core_pkg::fs_fetch;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= core_pkg::fs_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // Line request address.
   // A redirect wins over a push in the same cycle.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         line_pc <= '0;
      end else if (jump_branch_valid) begin
         line_pc <= jump_branch_address & LINE_MASK;
      end else if (fill.push) begin
         line_pc <= line_pc + core_pkg::addr_t'(icache_pkg::LINE_BYTES);
      end
   end

   // Cache request is a level while there is room in the queue.
   assign icache_rd_en = (state == core_pkg::fs_fetch) && !fill.full;

   // A redirect kills the request in flight and whatever it returns now.
   assign icache_abort = jump_branch_valid;

   assign fill.fill_pc = line_pc;
   assign fill.flush   = jump_branch_valid;
   assign fill.push    = icache_dout_valid && !fill.full &&
                         (state == core_pkg::fs_fetch) && !jump_branch_valid;

endmodule

`default_nettype wire

// File: logic/line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module line_buffer #(
   parameter int LINE_DEPTH = 4
) (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire icache_pkg::line_t icache_dout,
   fill_ctrl_if.buffer            fill,
   line_head_if.buffer            head
);

   localparam int PTR_W = $clog2(LINE_DEPTH);

   // Queue storage for lines and the address each line was fetched from.
   icache_pkg::line_t line_mem [LINE_DEPTH];
   core_pkg::addr_t   pc_mem   [LINE_DEPTH];

   // Extra top bit counts wraps so full and empty can be told apart.
   logic [PTR_W:0]   wr_ptr;
   logic [PTR_W:0]   rd_ptr;
   logic [PTR_W-1:0] wr_idx;
   logic [PTR_W-1:0] rd_idx;
   logic             is_empty;
   logic             is_full;
   logic             pop_ok;

   assign wr_idx = wr_ptr[PTR_W-1:0];
   assign rd_idx = rd_ptr[PTR_W-1:0];

   assign is_empty = (wr_ptr == rd_ptr);
   assign is_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) && (wr_idx == rd_idx);

   // Ignore a pop against an empty queue.
   assign pop_ok = head.pop && !is_empty;

   // Pointer update.
   // A flush clears the whole queue at the edge.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else if (fill.flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (fill.push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Write the returned line at the tail.
   always_ff @(posedge clk) begin
      if (fill.push) begin
         line_mem[wr_idx] <= icache_dout;
         pc_mem[wr_idx]   <= fill.fill_pc;
      end
   end

   assign fill.full = is_full;

   // Head of the queue.
   assign head.head_line = line_mem[rd_idx];
   assign head.head_pc   = pc_mem[rd_idx];
   assign head.empty     = is_empty;

endmodule

`default_nettype wire

// File: logic/dispatch_port.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_port (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  jump_branch_valid,
   input  wire core_pkg::addr_t jump_branch_address,
   input  wire                  dispatch_rd_en,
   output core_pkg::inst_t      dispatch_inst,
   output core_pkg::addr_t      dispatch_pc_out,
   output logic                 dispatch_empty,
   line_head_if.reader          head
);

   localparam int              INST_W    = $bits(core_pkg::inst_t);
   localparam core_pkg::addr_t LINE_MASK =
      ~core_pkg::addr_t'(icache_pkg::LINE_BYTES - 1);
   localparam icache_pkg::word_sel_t LAST_WORD =
      icache_pkg::word_sel_t'(icache_pkg::WORDS_PER_LINE - 1);

   core_pkg::addr_t       inst_pc;
   icache_pkg::word_sel_t word_sel;
   logic                  rd_ok;

   assign word_sel = inst_pc[3:2];

   // Head line only counts if it is the line holding inst_pc.
   assign dispatch_empty = head.empty || (head.head_pc != (inst_pc & LINE_MASK));

   assign rd_ok = dispatch_rd_en && !dispatch_empty;

   // Instruction address.
   // A redirect overrides a read in the same cycle.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         inst_pc <= '0;
      end else if (jump_branch_valid) begin
         inst_pc <= jump_branch_address;
      end else if (rd_ok) begin
         inst_pc <= inst_pc + core_pkg::addr_t'(4);
      end
   end

   // Word select from the head line.
   always_comb begin
      dispatch_inst = head.head_line[word_sel*INST_W +: INST_W];
   end

   assign dispatch_pc_out = inst_pc;

   // The line can go once its last word is consumed.
   assign head.pop = rd_ok && (word_sel == LAST_WORD);

endmodule

`default_nettype wire

// File: logic/ifq.sv
`timescale 1ns/10ps
`default_nettype none

module ifq #(
   parameter int LINE_DEPTH = 4
) (
   input  wire                    clk,
   input  wire                    rst_n,
   // Instruction cache side.
   output core_pkg::addr_t        icache_pc_in,
   output logic                   icache_rd_en,
   output logic                   icache_abort,
   input  wire icache_pkg::line_t icache_dout,
   input  wire                    icache_dout_valid,
   // Dispatch side.
   output core_pkg::addr_t        dispatch_pc_out,
   output core_pkg::inst_t        dispatch_inst,
   output logic                   dispatch_empty,
   input  wire                    dispatch_rd_en,
   input  wire core_pkg::addr_t   dispatch_jump_branch_address,
   input  wire                    dispatch_jump_branch_valid
);

   fill_ctrl_if fill_bus ();
   line_head_if head_bus ();

   // Line request address and queue control.
   fetch_pc_gen i_fetch_pc_gen (
      .clk                 (clk),
      .rst_n               (rst_n),
      .jump_branch_valid   (dispatch_jump_branch_valid),
      .jump_branch_address (dispatch_jump_branch_address),
      .icache_dout_valid   (icache_dout_valid),
      .icache_rd_en        (icache_rd_en),
      .icache_abort        (icache_abort),
      .fill                (fill_bus.generator)
   );

   // Queue of fetched lines.
   line_buffer #(
      .LINE_DEPTH (LINE_DEPTH)
   ) i_line_buffer (
      .clk         (clk),
      .rst_n       (rst_n),
      .icache_dout (icache_dout),
      .fill        (fill_bus.buffer),
      .head        (head_bus.buffer)
   );

   // One word per read towards dispatch.
   dispatch_port i_dispatch_port (
      .clk                 (clk),
      .rst_n               (rst_n),
      .jump_branch_valid   (dispatch_jump_branch_valid),
      .jump_branch_address (dispatch_jump_branch_address),
      .dispatch_rd_en      (dispatch_rd_en),
      .dispatch_inst       (dispatch_inst),
      .dispatch_pc_out     (dispatch_pc_out),
      .dispatch_empty      (dispatch_empty),
      .head                (head_bus.reader)
   );

   assign icache_pc_in = fill_bus.fill_pc;

endmodule

`default_nettype wire

// File: bench/ifq_sva.sv
`timescale 1ns/10ps
`default_nettype none

module ifq_sva (
   input wire                         clk,
   input wire                         rst_n,
   input wire core_pkg::fetch_state_t state,
   input wire                         jump_valid,
   input wire core_pkg::addr_t        jump_addr,
   input wire core_pkg::addr_t        icache_pc_in,
   input wire                         icache_rd_en,
   input wire                         icache_abort,
   input wire                         push,
   input wire                         dispatch_empty,
   input wire core_pkg::addr_t        dispatch_pc_out
);

   // Read by the testbench after every cycle.
   int fail_count = 0;

   // Nothing is requested or offered before the boot redirect.
   a_idle_quiet : assert property (@(posedge clk) disable iff (!rst_n)
      (state == core_pkg::fs_idle && !jump_valid) |->
         (!icache_rd_en && !icache_abort && dispatch_empty))
      else begin
         $error("cache request or dispatch word seen before the first redirect");
         fail_count++;
      end

   a_abort_on_redirect : assert property (@(posedge clk) disable iff (!rst_n)
      jump_valid |-> icache_abort)
      else begin
         $error("icache_abort low in a redirect cycle");
         fail_count++;
      end

   // Both addresses pick up the target one cycle after the redirect.
   a_redirect_target : assert property (@(posedge clk) disable iff (!rst_n)
      jump_valid |=> (dispatch_pc_out == $past(jump_addr)) &&
                     (icache_pc_in == ($past(jump_addr) & 32'hFFFF_FFF0)))
      else begin
         $error("fetch or dispatch address did not follow the redirect target");
         fail_count++;
      end

   a_line_aligned : assert property (@(posedge clk) disable iff (!rst_n)
      icache_pc_in[3:0] == 4'h0)
      else begin
         $error("icache_pc_in is not 16-byte aligned");
         fail_count++;
      end

   a_pc_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (!push && !jump_valid) |=> $stable(icache_pc_in))
      else begin
         $error("icache_pc_in moved without a push or a redirect");
         fail_count++;
      end

   a_pc_step : assert property (@(posedge clk) disable iff (!rst_n)
      (push && !jump_valid) |=> (icache_pc_in == $past(icache_pc_in) + 32'd16))
      else begin
         $error("icache_pc_in did not step by one line after a push");
         fail_count++;
      end

endmodule

bind ifq ifq_sva i_ifq_sva (
   .clk             (clk),
   .rst_n           (rst_n),
   .state           (i_fetch_pc_gen.state),
   .jump_valid      (dispatch_jump_branch_valid),
   .jump_addr       (dispatch_jump_branch_address),
   .icache_pc_in    (icache_pc_in),
   .icache_rd_en    (icache_rd_en),
   .icache_abort    (icache_abort),
   .push            (fill_bus.push),
   .dispatch_empty  (dispatch_empty),
   .dispatch_pc_out (dispatch_pc_out)
);

`default_nettype wire

// File: bench/ifq_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ifq_tb;

   localparam int          LINE_DEPTH     = 4;
   localparam int          NUM_WORDS      = 2000;
   localparam int          SEED           = 29279;
   localparam int          STALL_LIMIT    = 64;
   localparam int          HOLD_CYCLES    = 20;
   localparam int          PROGRESS_LIMIT = 400;
   localparam int          RUN_LIMIT      = 100000;
   localparam logic [31:0] WORD_KEY       = 32'h5A5A_0000;

   logic              clk = 1'b0;
   logic              rst_n;
   core_pkg::addr_t   icache_pc_in;
   logic              icache_rd_en;
   logic              icache_abort;
   icache_pkg::line_t icache_dout;
   logic              icache_dout_valid;
   core_pkg::addr_t   dispatch_pc_out;
   core_pkg::inst_t   dispatch_inst;
   logic              dispatch_empty;
   logic              dispatch_rd_en;
   core_pkg::addr_t   dispatch_jump_branch_address;
   logic              dispatch_jump_branch_valid;

   // Expected address of the next word taken.
   core_pkg::addr_t exp_pc;
   int              words;
   int              idle_cycles;
   int              run_cycles;
   // Set while icache_rd_en must stay low.
   logic            hold_check;
   // Cache model with one request in flight.
   logic            req_pending;
   int              req_delay;

   always #2 clk = ~clk;

   ifq #(
      .LINE_DEPTH (LINE_DEPTH)
   ) i_ifq (
      .clk                          (clk),
      .rst_n                        (rst_n),
      .icache_pc_in                 (icache_pc_in),
      .icache_rd_en                 (icache_rd_en),
      .icache_abort                 (icache_abort),
      .icache_dout                  (icache_dout),
      .icache_dout_valid            (icache_dout_valid),
      .dispatch_pc_out              (dispatch_pc_out),
      .dispatch_inst                (dispatch_inst),
      .dispatch_empty               (dispatch_empty),
      .dispatch_rd_en               (dispatch_rd_en),
      .dispatch_jump_branch_address (dispatch_jump_branch_address),
      .dispatch_jump_branch_valid   (dispatch_jump_branch_valid)
   );

   // Every cached word holds its own byte address XOR the key.
   function automatic icache_pkg::line_t line_at(input core_pkg::addr_t line_pc);
      icache_pkg::line_t line;
      for (int k = 0; k < icache_pkg::WORDS_PER_LINE; k++) begin
         line[32*k +: 32] = (line_pc + 32'(4 * k)) ^ WORD_KEY;
      end
      return line;
   endfunction

   function automatic core_pkg::addr_t random_target();
      return $urandom & 32'hFFFF_FFFC;
   endfunction

   task automatic fail_and_stop(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic value_error(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      fail_and_stop($sformatf("ERROR at %0t ns: %s expected %h, got %h",
                              $time, name, expected, actual));
   endtask

   // Answers a request after 1 to 3 cycles; an abort drops it.
   task automatic cache_step(input logic aborted);
      icache_dout_valid = 1'b0;
      if (aborted) begin
         req_pending = 1'b0;
      end else if (req_pending) begin
         req_delay = req_delay - 1;
         if (req_delay == 0) begin
            icache_dout       = line_at(icache_pc_in);
            icache_dout_valid = 1'b1;
            req_pending       = 1'b0;
         end
      end else if (icache_rd_en) begin
         req_pending = 1'b1;
         req_delay   = 1 + ($urandom % 3);
      end
   endtask

   // One clock cycle, inputs driven at the falling edge.
   // Dispatch outputs do not depend on this cycle's inputs.
   task automatic cycle(input logic want_rd, input logic want_jump,
                        input core_pkg::addr_t target);
      logic take;
      @(negedge clk);
      run_cycles++;
      if (i_ifq.i_ifq_sva.fail_count != 0) begin
         fail_and_stop("A protocol assertion bound into ifq failed.");
      end
      if (run_cycles > RUN_LIMIT) begin
         fail_and_stop("The run went on for too many cycles.");
      end
      if (hold_check) begin
         assert (icache_rd_en == 1'b0)
            else value_error("icache_rd_en", 32'd0, 32'(icache_rd_en));
      end
      take = want_rd && !want_jump && !dispatch_empty;
      if (take) begin
         assert (dispatch_pc_out == exp_pc)
            else value_error("dispatch_pc_out", exp_pc, dispatch_pc_out);
         assert (dispatch_inst == (exp_pc ^ WORD_KEY))
            else value_error("dispatch_inst", exp_pc ^ WORD_KEY, dispatch_inst);
         // A queue slot opens after the edge once word 3 is taken.
         if (exp_pc[3:2] == 2'd3) begin
            hold_check = 1'b0;
         end
         exp_pc      = exp_pc + 32'd4;
         words       = words + 1;
         idle_cycles = 0;
      end else begin
         idle_cycles = idle_cycles + 1;
      end
      if (want_jump) begin
         exp_pc = target;
      end
      dispatch_rd_en               = want_rd;
      dispatch_jump_branch_valid   = want_jump;
      dispatch_jump_branch_address = target;
      cache_step(want_jump);
   endtask

   // Long dispatch stall followed by reads.
   task automatic run_stall();
      int n;
      n = 0;
      while (icache_rd_en) begin
         if (n >= STALL_LIMIT) begin
            fail_and_stop("icache_rd_en did not drop while dispatch was stalled.");
         end
         cycle(1'b0, 1'b0, '0);
         n++;
      end
      hold_check = 1'b1;
      for (n = 0; n < HOLD_CYCLES; n++) begin
         cycle(1'b0, 1'b0, '0);
      end
      n = 0;
      while (hold_check) begin
         if (n >= icache_pkg::WORDS_PER_LINE + 2) begin
            fail_and_stop("No read of word 3 happened after the stall.");
         end
         cycle(1'b1, 1'b0, '0);
         n++;
      end
   endtask

   initial begin
      int   next_stall;
      logic rd;
      logic jump;
      rst_n                        = 1'b0;
      icache_dout                  = '0;
      icache_dout_valid            = 1'b0;
      dispatch_rd_en               = 1'b0;
      dispatch_jump_branch_address = '0;
      dispatch_jump_branch_valid   = 1'b0;
      exp_pc                       = '0;
      words                        = 0;
      idle_cycles                  = 0;
      run_cycles                   = 0;
      hold_check                   = 1'b0;
      req_pending                  = 1'b0;
      req_delay                    = 0;
      next_stall                   = 500;
      void'($urandom(SEED));
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // Boot address.
      cycle(1'b0, 1'b1, random_target());
      while (words < NUM_WORDS) begin
         if (idle_cycles > PROGRESS_LIMIT) begin
            fail_and_stop("No instruction was dispatched for too long.");
         end
         if (words >= next_stall) begin
            run_stall();
            next_stall = next_stall + 700;
         end else begin
            rd   = ($urandom % 10) < 7;
            jump = ($urandom % 100) == 0;
            cycle(rd, jump, random_target());
         end
      end
      @(negedge clk);
      if (i_ifq.i_ifq_sva.fail_count != 0) begin
         fail_and_stop("A protocol assertion bound into ifq failed.");
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: files.f
logic/core_pkg.sv
logic/icache_pkg.sv
logic/fetch_ifs.sv
logic/fetch_pc_gen.sv
logic/line_buffer.sv
logic/dispatch_port.sv
logic/ifq.sv
bench/ifq_sva.sv
bench/ifq_tb.sv
